//--- rtl/bpu_macros.svh
// bpu sizing macros
// table depths, index and tag widths, history length, RAS size
// and the fetch address taken out of reset

`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// fetch address after reset
`define BPU_INIT_PC     32'h1c00_0000

// BTB and BHT geometry, one bank per slot
`define BPU_IDX_LEN     9     // {pc[17:12]^pc[11:6], pc[5:3]}
`define BPU_TAB_DEPTH   512   // entries per bank
`define BPU_TAG_LEN     8     // pc[19:12]

// local history and pattern table
`define BPU_HIST_LEN    5
`define BPU_PHT_PC_LEN  8     // pc[10:3]
`define BPU_PHT_LEN     13    // history + pc bits

// return address stack
`define BPU_RAS_DEPTH   8
`define BPU_RAS_LEN     3     // pointer width

`endif

//--- rtl/bpu_pkg.sv
// bpu shared types
// address and field typedefs, branch type encoding,
// table index hash and tag extraction

`default_nettype none

`include "bpu_macros.svh"

package bpu_pkg;

    typedef logic [31:0]                  addr_t;     // instruction address
    typedef logic [`BPU_IDX_LEN-1:0]      btb_idx_t;  // BTB / BHT row
    typedef logic [`BPU_PHT_LEN-1:0]      pht_idx_t;  // PHT row
    typedef logic [`BPU_TAG_LEN-1:0]      tag_t;
    typedef logic [`BPU_HIST_LEN-1:0]     hist_t;     // newest outcome in bit 0
    typedef logic [1:0]                   scnt_t;     // msb set means taken
    typedef logic [`BPU_RAS_LEN-1:0]      ras_ptr_t;

    // plain jumps live as BR_COND with a counter trained taken
    typedef enum logic [1:0] {
        BR_NPC  = 2'd0,  // no branch
        BR_COND = 2'd1,
        BR_CALL = 2'd2,
        BR_RET  = 2'd3
    } br_type_e;

    // fold pc[17:6] down to 6 bits, keep block offset bits on the bottom
    function automatic btb_idx_t bpu_hash(input addr_t pc);
        return {pc[17:12] ^ pc[11:6], pc[5:3]};
    endfunction

    // tag sits right above the folded index bits
    function automatic tag_t bpu_tag(input addr_t pc);
        return pc[`BPU_TAG_LEN+11:12];
    endfunction

endpackage

`default_nettype wire

//--- rtl/bpu_btb.sv
// bpu branch target buffer
// two banks, one per fetch slot, each with a hashed index and a tag.
// holds target and branch type; written by backend updates only

`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module bpu_btb import bpu_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,

    input  wire addr_t        rd_pc_i,        // current fetch pc
    output logic [1:0]        hit_o,
    output addr_t [1:0]       target_o,
    output br_type_e [1:0]    br_type_o,

    input  wire logic         upd_valid_i,
    input  wire addr_t        upd_pc_i,
    input  wire addr_t        upd_target_i,
    input  wire br_type_e     upd_br_type_i
);

    // payload arrays, no reset
    tag_t     tag_mem    [2][`BPU_TAB_DEPTH];
    addr_t    target_mem [2][`BPU_TAB_DEPTH];
    br_type_e type_mem   [2][`BPU_TAB_DEPTH];

    logic [1:0][`BPU_TAB_DEPTH-1:0] valid_q;  // per bank, per row

    btb_idx_t rd_idx;
    tag_t     rd_tag;
    btb_idx_t upd_idx;
    logic     upd_we;

    assign rd_idx  = bpu_hash(rd_pc_i);
    assign rd_tag  = bpu_tag(rd_pc_i);
    assign upd_idx = bpu_hash(upd_pc_i);
    assign upd_we  = upd_valid_i && (upd_br_type_i != BR_NPC);  // plain insns never stored

    // both banks read at the same row
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            hit_o[b]     = valid_q[b][rd_idx] && (tag_mem[b][rd_idx] == rd_tag);
            target_o[b]  = target_mem[b][rd_idx];
            br_type_o[b] = type_mem[b][rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;  // all rows invalid
        end else if (upd_we) begin
            valid_q[upd_pc_i[2]][upd_idx] <= 1'b1;
        end
    end

    // bank picked by pc[2] of the resolved branch
    always_ff @(posedge clk) begin
        if (upd_we) begin
            tag_mem[upd_pc_i[2]][upd_idx]    <= bpu_tag(upd_pc_i);
            target_mem[upd_pc_i[2]][upd_idx] <= upd_target_i;
            type_mem[upd_pc_i[2]][upd_idx]   <= upd_br_type_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_bht.sv
// bpu local branch history table
// two tagged banks of 5-bit histories, same hash as the BTB.
// a tag miss reads as zero history; updates shift in the outcome

`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module bpu_bht import bpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,

    input  wire addr_t      rd_pc_i,
    output hist_t [1:0]     hist_o,       // per slot, zero on miss

    input  wire logic       upd_valid_i,
    input  wire addr_t      upd_pc_i,
    input  wire br_type_e   upd_br_type_i,
    input  wire logic       upd_taken_i,
    output hist_t           upd_hist_o    // history before this update
);

    tag_t  tag_mem  [2][`BPU_TAB_DEPTH];
    hist_t hist_mem [2][`BPU_TAB_DEPTH];

    logic [1:0][`BPU_TAB_DEPTH-1:0] valid_q;

    btb_idx_t rd_idx;
    btb_idx_t upd_idx;
    logic     upd_bank;
    logic     upd_hit;
    logic     upd_we;

    assign rd_idx   = bpu_hash(rd_pc_i);
    assign upd_idx  = bpu_hash(upd_pc_i);
    assign upd_bank = upd_pc_i[2];
    assign upd_we   = upd_valid_i && (upd_br_type_i != BR_NPC);

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            if (valid_q[b][rd_idx] && (tag_mem[b][rd_idx] == bpu_tag(rd_pc_i))) begin
                hist_o[b] = hist_mem[b][rd_idx];
            end else begin
                hist_o[b] = '0;
            end
        end
    end

    // old history goes to the PHT; zero when the entry belongs to another branch
    assign upd_hit    = valid_q[upd_bank][upd_idx] &&
                        (tag_mem[upd_bank][upd_idx] == bpu_tag(upd_pc_i));
    assign upd_hist_o = upd_hit ? hist_mem[upd_bank][upd_idx] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (upd_we) begin
            valid_q[upd_bank][upd_idx] <= 1'b1;
        end
    end

    // on a miss upd_hist_o is zero, so the shift restarts from the outcome alone
    always_ff @(posedge clk) begin
        if (upd_we) begin
            tag_mem[upd_bank][upd_idx]  <= bpu_tag(upd_pc_i);
            hist_mem[upd_bank][upd_idx] <= {upd_hist_o[`BPU_HIST_LEN-2:0], upd_taken_i};
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_pht.sv
// bpu pattern history table
// two banks of 2-bit saturating counters indexed by
// {local history, pc[10:3]}; trained by read-modify-write

`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module bpu_pht import bpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,

    input  wire addr_t      rd_pc_i,
    input  wire hist_t [1:0] rd_hist_i,   // from the BHT, per slot
    output scnt_t [1:0]     scnt_o,

    input  wire logic       upd_valid_i,
    input  wire addr_t      upd_pc_i,
    input  wire br_type_e   upd_br_type_i,
    input  wire logic       upd_taken_i,
    input  wire hist_t      upd_hist_i    // history before the update
);

    localparam int unsigned PHT_DEPTH = 1 << `BPU_PHT_LEN;

    scnt_t [1:0][PHT_DEPTH-1:0] pht_q;  // counters start strongly not taken

    pht_idx_t upd_idx;
    logic     upd_bank;
    logic     upd_we;
    scnt_t    upd_cnt;

    // step toward the outcome, saturate at 0 and 3
    function automatic scnt_t next_scnt(input scnt_t cnt, input logic taken);
        if (taken) begin
            return (cnt == 2'd3) ? cnt : cnt + 2'd1;
        end
        return (cnt == 2'd0) ? cnt : cnt - 2'd1;
    endfunction

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            scnt_o[b] = pht_q[b][{rd_hist_i[b], rd_pc_i[`BPU_PHT_PC_LEN+2:3]}];
        end
    end

    assign upd_idx  = {upd_hist_i, upd_pc_i[`BPU_PHT_PC_LEN+2:3]};
    assign upd_bank = upd_pc_i[2];
    assign upd_we   = upd_valid_i && (upd_br_type_i != BR_NPC);
    assign upd_cnt  = pht_q[upd_bank][upd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pht_q <= '0;
        end else if (upd_we) begin
            pht_q[upd_bank][upd_idx] <= next_scnt(upd_cnt, upd_taken_i);
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_ras.sv
// bpu return address stack
// eight entries with a top pointer; calls push pc+4, returns pop.
// pointer wraps, so deep call chains overwrite the oldest entry

`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module bpu_ras import bpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,

    output addr_t           top_o,        // predicted return address

    input  wire logic       upd_valid_i,
    input  wire addr_t      upd_pc_i,
    input  wire br_type_e   upd_br_type_i
);

    addr_t [`BPU_RAS_DEPTH-1:0] stack_q;
    ras_ptr_t                   top_q;     // points at the current top
    ras_ptr_t                   push_ptr;
    logic                       push;
    logic                       pop;

    assign push     = upd_valid_i && (upd_br_type_i == BR_CALL);
    assign pop      = upd_valid_i && (upd_br_type_i == BR_RET);
    assign push_ptr = top_q + ras_ptr_t'(1);  // wraps at depth

    assign top_o = stack_q[top_q];

    // empty stack reads entry 0, which reset leaves at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= '0;
        end else if (push) begin
            top_q <= push_ptr;
        end else if (pop) begin
            top_q <= top_q - ras_ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stack_q <= '0;
        end else if (push) begin
            stack_q[push_ptr] <= upd_pc_i + 32'd4;  // return lands after the call
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_pc_gen.sv
// bpu fetch pc and next-pc selection
// holds the fetch pc, picks the first taken slot of the block
// and builds the slot mask; redirect overrides the prediction

`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module bpu_pc_gen import bpu_pkg::*; (
    input  wire logic           clk,
    input  wire logic           rst_n,

    input  wire logic           ready_i,
    input  wire logic           redirect_i,
    input  wire addr_t          redirect_pc_i,

    input  wire logic [1:0]     btb_hit_i,
    input  wire addr_t [1:0]    btb_target_i,
    input  wire br_type_e [1:0] btb_type_i,
    input  wire scnt_t [1:0]    scnt_i,
    input  wire addr_t          ras_top_i,

    output logic                valid_o,
    output addr_t               pc_o,
    output addr_t               target_o,
    output logic                taken_o,
    output br_type_e            br_type_o,
    output logic [1:0]          mask_o
);

    addr_t      pc_q;
    logic [1:0] slot_tk;   // slot predicts taken
    addr_t      seq_pc;    // next aligned block

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            slot_tk[s] = btb_hit_i[s] && (btb_type_i[s] != BR_NPC) &&
                         ((btb_type_i[s] == BR_CALL) || (btb_type_i[s] == BR_RET) ||
                          scnt_i[s][1]);
        end
        slot_tk[0] = slot_tk[0] && !pc_q[2];  // slot 0 skipped when entering at slot 1
    end

    assign seq_pc = {pc_q[31:3], 3'b000} + 32'd8;

    // first taken slot wins
    always_comb begin
        target_o  = seq_pc;
        taken_o   = 1'b0;
        br_type_o = BR_NPC;
        mask_o    = {1'b1, !pc_q[2]};  // fall through covers the rest of the block
        for (int s = 1; s >= 0; s--) begin
            if (slot_tk[s]) begin
                taken_o   = 1'b1;
                br_type_o = btb_type_i[s];
                target_o  = (btb_type_i[s] == BR_RET) ? ras_top_i : btb_target_i[s];
                mask_o    = (s == 0) ? 2'b01 : {1'b1, !pc_q[2]};
            end
        end
    end

    // redirect beats the handshake; accept only once valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= `BPU_INIT_PC;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b1;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (ready_i && valid_o) begin
                pc_q <= target_o;
            end
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- rtl/bpu.sv
// branch prediction unit top
// two-slot fetch predictor built from BTB, local history table,
// pattern table and return stack, trained by the backend port

`timescale 1ns/1ps
`default_nettype none

module bpu import bpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,

    // fetch side
    input  wire logic       ready_i,
    output logic            valid_o,
    output addr_t           pc_o,
    output addr_t           target_o,
    output logic            taken_o,
    output br_type_e        br_type_o,
    output logic [1:0]      mask_o,

    // backend correction port
    input  wire logic       upd_valid_i,
    input  wire addr_t      upd_pc_i,
    input  wire addr_t      upd_target_i,
    input  wire br_type_e   upd_br_type_i,
    input  wire logic       upd_taken_i,
    input  wire logic       redirect_i
);

    logic [1:0]     btb_hit;
    addr_t [1:0]    btb_target;
    br_type_e [1:0] btb_type;
    hist_t [1:0]    bht_hist;
    hist_t          upd_hist;    // old history of the trained entry
    scnt_t [1:0]    pht_scnt;
    addr_t          ras_top;

    bpu_btb btb_i (
        .clk, .rst_n,
        .rd_pc_i       (pc_o),
        .hit_o         (btb_hit),
        .target_o      (btb_target),
        .br_type_o     (btb_type),
        .upd_valid_i, .upd_pc_i, .upd_target_i, .upd_br_type_i
    );

    bpu_bht bht_i (
        .clk, .rst_n,
        .rd_pc_i       (pc_o),
        .hist_o        (bht_hist),
        .upd_valid_i, .upd_pc_i, .upd_br_type_i, .upd_taken_i,
        .upd_hist_o    (upd_hist)
    );

    bpu_pht pht_i (
        .clk, .rst_n,
        .rd_pc_i       (pc_o),
        .rd_hist_i     (bht_hist),
        .scnt_o        (pht_scnt),
        .upd_valid_i, .upd_pc_i, .upd_br_type_i, .upd_taken_i,
        .upd_hist_i    (upd_hist)
    );

    bpu_ras ras_i (
        .clk, .rst_n,
        .top_o         (ras_top),
        .upd_valid_i, .upd_pc_i, .upd_br_type_i
    );

    // redirect address rides on the update pc
    bpu_pc_gen pc_gen_i (
        .clk, .rst_n,
        .ready_i, .redirect_i,
        .redirect_pc_i (upd_pc_i),
        .btb_hit_i     (btb_hit),
        .btb_target_i  (btb_target),
        .btb_type_i    (btb_type),
        .scnt_i        (pht_scnt),
        .ras_top_i     (ras_top),
        .valid_o, .pc_o, .target_o, .taken_o, .br_type_o, .mask_o
    );

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// testbench clock and reset
// free-running clock, active-low reset held for a few cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released on a rising edge like the rest of the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_bpu.sv
// bpu testbench
// drives fetch handshake, backend updates and redirects into the DUT,
// keeps its own model of BTB, BHT, PHT and RAS, and compares every cycle

`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module tb_bpu import bpu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;  // roughly 5x the ~800 cycles of all tests

    logic       clk;
    logic       rst_n;
    logic       ready;
    logic       redirect;
    logic       upd_valid;
    addr_t      upd_pc;
    addr_t      upd_target;
    br_type_e   upd_type;
    logic       upd_taken;
    logic       dut_valid;
    addr_t      dut_pc;
    addr_t      dut_target;
    logic       dut_taken;
    br_type_e   dut_type;
    logic [1:0] dut_mask;

    // model state, mirrors the DUT after each edge
    addr_t                               m_pc;
    logic                                m_valid;
    logic [1:0][`BPU_TAB_DEPTH-1:0]      btb_v;
    tag_t                                btb_tag [2][`BPU_TAB_DEPTH];
    addr_t                               btb_tgt [2][`BPU_TAB_DEPTH];
    br_type_e                            btb_ty  [2][`BPU_TAB_DEPTH];
    logic [1:0][`BPU_TAB_DEPTH-1:0]      bht_v;
    tag_t                                bht_tag [2][`BPU_TAB_DEPTH];
    hist_t                               bht_h   [2][`BPU_TAB_DEPTH];
    scnt_t [1:0][(1<<`BPU_PHT_LEN)-1:0]  pht_m;
    addr_t [`BPU_RAS_DEPTH-1:0]          ras_m;
    ras_ptr_t                            ras_top;

    int unsigned cycle_count = 0;
    addr_t       mix_pc [8];  // small pc pool, rows and tags collide on purpose

    tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

    bpu bpu_i (
        .clk, .rst_n,
        .ready_i(ready), .valid_o(dut_valid), .pc_o(dut_pc), .target_o(dut_target),
        .taken_o(dut_taken), .br_type_o(dut_type), .mask_o(dut_mask),
        .upd_valid_i(upd_valid), .upd_pc_i(upd_pc), .upd_target_i(upd_target),
        .upd_br_type_i(upd_type), .upd_taken_i(upd_taken), .redirect_i(redirect)
    );

    function automatic btb_idx_t row_of(input addr_t pc);
        return {pc[17:12] ^ pc[11:6], pc[5:3]};  // folded high bits over block offset
    endfunction

    function automatic tag_t tag_of(input addr_t pc);
        return pc[19:12];
    endfunction

    // local history of the branch at pc, zero when the row holds another branch
    function automatic hist_t hist_of(input logic b, input addr_t pc);
        btb_idx_t r;
        r = row_of(pc);
        return (bht_v[b][r] && bht_tag[b][r] == tag_of(pc)) ? bht_h[b][r] : '0;
    endfunction

    // expected next fetch address, taken flag, type and slot mask for pc
    function automatic void predict_next(input addr_t pc, output addr_t tgt, output logic tk,
                                         output br_type_e ty, output logic [1:0] mk);
        btb_idx_t   r;
        scnt_t      cnt;
        logic [1:0] slot_tk;
        r   = row_of(pc);
        tgt = {pc[31:3], 3'b000} + 32'd8;  // fall through
        tk  = 1'b0;
        ty  = BR_NPC;
        mk  = {1'b1, ~pc[2]};
        for (int s = 0; s < 2; s++) begin
            cnt = pht_m[s][{hist_of(1'(s), pc), pc[10:3]}];
            slot_tk[s] = btb_v[s][r] && (btb_tag[s][r] == tag_of(pc)) &&
                         (btb_ty[s][r] != BR_NPC) &&
                         (btb_ty[s][r] == BR_CALL || btb_ty[s][r] == BR_RET || cnt >= 2'd2);
        end
        if (pc[2]) begin
            slot_tk[0] = 1'b0;  // entered at slot 1
        end
        for (int s = 0; s < 2; s++) begin
            if (slot_tk[s] && !tk) begin
                tk  = 1'b1;
                ty  = btb_ty[s][r];
                tgt = (ty == BR_RET) ? ras_m[ras_top] : btb_tgt[s][r];
                mk  = (s == 0) ? 2'b01 : {1'b1, ~pc[2]};
            end
        end
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        fail_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_type(input br_type_e got, input br_type_e exp, input string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_mask(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    // one-cycle strobe on the correction port
    task automatic send_update(input addr_t pc, input addr_t tgt, input br_type_e ty,
                               input logic tk);
        @(posedge clk);
        upd_valid  <= 1'b1;
        upd_pc     <= pc;
        upd_target <= tgt;
        upd_type   <= ty;
        upd_taken  <= tk;
        @(posedge clk);
        upd_valid  <= 1'b0;
    endtask

    task automatic redirect_to(input addr_t pc);
        @(posedge clk);
        redirect <= 1'b1;
        upd_pc   <= pc;  // redirect address rides on upd_pc
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    // model advance, sees the inputs the DUT samples at this edge
    always @(posedge clk) begin : model_edge
        addr_t      nxt_tgt;
        logic       nxt_tk;
        br_type_e   nxt_ty;
        logic [1:0] nxt_mk;
        logic       b;
        btb_idx_t   r;
        hist_t      old_h;
        scnt_t      cnt;
        if (!rst_n) begin
            m_pc    = `BPU_INIT_PC;
            m_valid = 1'b0;
            btb_v   = '0;
            bht_v   = '0;
            pht_m   = '0;
            ras_m   = '0;
            ras_top = '0;
        end else begin
            predict_next(m_pc, nxt_tgt, nxt_tk, nxt_ty, nxt_mk);  // tables before the write
            b = upd_pc[2];
            r = row_of(upd_pc);
            if (upd_valid && upd_type != BR_NPC) begin
                old_h = hist_of(b, upd_pc);
                cnt   = pht_m[b][{old_h, upd_pc[10:3]}];
                if (upd_taken && cnt != 2'd3) begin
                    cnt = cnt + 2'd1;
                end else if (!upd_taken && cnt != 2'd0) begin
                    cnt = cnt - 2'd1;
                end
                pht_m[b][{old_h, upd_pc[10:3]}] = cnt;
                btb_v[b][r]   = 1'b1;
                btb_tag[b][r] = tag_of(upd_pc);
                btb_tgt[b][r] = upd_target;
                btb_ty[b][r]  = upd_type;
                bht_v[b][r]   = 1'b1;
                bht_tag[b][r] = tag_of(upd_pc);
                bht_h[b][r]   = {old_h[`BPU_HIST_LEN-2:0], upd_taken};
            end
            if (upd_valid && upd_type == BR_CALL) begin
                ras_top        = ras_top + ras_ptr_t'(1);
                ras_m[ras_top] = upd_pc + 32'd4;
            end else if (upd_valid && upd_type == BR_RET) begin
                ras_top = ras_top - ras_ptr_t'(1);
            end
            if (redirect) begin
                m_pc = upd_pc;
            end else if (ready && m_valid) begin
                m_pc = nxt_tgt;
            end
            m_valid = 1'b1;
        end
    end

    // outputs settle by the falling edge
    always @(negedge clk) begin : compare_outputs
        addr_t      e_tgt;
        logic       e_tk;
        br_type_e   e_ty;
        logic [1:0] e_mk;
        if (rst_n === 1'b1) begin
            predict_next(m_pc, e_tgt, e_tk, e_ty, e_mk);
            check_bit(dut_valid, m_valid, "valid_o");
            check_addr(dut_pc, m_pc, "pc_o");
            check_addr(dut_target, e_tgt, "target_o");
            check_bit(dut_taken, e_tk, "taken_o");
            check_type(dut_type, e_ty, "br_type_o");
            check_mask(dut_mask, e_mk, "mask_o");
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin : stimulus
        addr_t       held_pc;
        logic        prev_ready;
        logic [31:0] r;
        int          n;
        r          = $urandom(32'h3a3b_f65a);  // one seed for the whole run
        ready      = 1'b0;
        redirect   = 1'b0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_target = '0;
        upd_type   = BR_NPC;
        upd_taken  = 1'b0;
        mix_pc = '{32'h1c00_0100, 32'h1c00_0104, 32'h1c00_0108, 32'h1c00_010c,
                   32'h1c04_0100, 32'h1c04_0104, 32'h1c00_1140, 32'h1c00_1144};

        // reset, then sequential fetch of aligned blocks
        @(posedge rst_n);
        @(negedge clk);
        check_addr(dut_pc, `BPU_INIT_PC, "pc_o after reset");
        n = 0;
        while (dut_valid !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 10) begin
                fail_run("valid_o did not rise within 10 cycles of reset release");
            end
        end
        @(posedge clk);
        ready <= 1'b1;
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            check_addr(dut_pc, `BPU_INIT_PC + 32'(8 * k), "pc_o sequential");
            check_mask(dut_mask, 2'b11, "mask_o sequential");
        end

        // back-pressure, pc holds whenever ready was low at the edge
        prev_ready = 1'b1;
        held_pc    = dut_pc;
        for (int k = 0; k < 40; k++) begin
            r = $urandom;
            @(posedge clk);
            ready <= r[0];
            @(negedge clk);
            if (!prev_ready) begin
                check_addr(dut_pc, held_pc, "pc_o during stall");
            end
            held_pc    = dut_pc;
            prev_ready = r[0];
        end

        // conditional branch in slot 0, trained up then down
        @(posedge clk);
        ready <= 1'b0;
        redirect_to(32'h1c00_2040);
        repeat (10) send_update(32'h1c00_2040, 32'h1c00_8000, BR_COND, 1'b1);
        @(negedge clk);
        check_bit(dut_taken, 1'b1, "taken_o after taken training");
        check_addr(dut_target, 32'h1c00_8000, "target_o from BTB");
        check_mask(dut_mask, 2'b01, "mask_o ends at slot 0");
        repeat (10) send_update(32'h1c00_2040, 32'h1c00_8000, BR_COND, 1'b0);
        @(negedge clk);
        check_bit(dut_taken, 1'b0, "taken_o after not-taken training");

        // return entry first, its own pop leaves the stack pointer wrapped
        send_update(32'h1c00_5008, 32'h0, BR_RET, 1'b1);
        send_update(32'h1c00_3004, 32'h1c00_5000, BR_CALL, 1'b1);
        redirect_to(32'h1c00_5008);
        @(negedge clk);
        check_type(dut_type, BR_RET, "br_type_o at return");
        check_addr(dut_target, 32'h1c00_3008, "target_o return to outer call");
        send_update(32'h1c00_3104, 32'h1c00_5000, BR_CALL, 1'b1);  // nested call
        @(negedge clk);
        check_addr(dut_target, 32'h1c00_3108, "target_o return to inner call");
        send_update(32'h1c00_5008, 32'h0, BR_RET, 1'b1);
        @(negedge clk);
        check_addr(dut_target, 32'h1c00_3008, "target_o return after pop");

        // redirect wins while ready is low
        redirect_to(32'h1c00_0204);
        @(negedge clk);
        check_addr(dut_pc, 32'h1c00_0204, "pc_o after redirect");
        check_mask(dut_mask, 2'b10, "mask_o entering at slot 1");

        // random mix, checked by the model every cycle
        repeat (600) begin
            r = $urandom;
            @(posedge clk);
            ready      <= r[0] | r[1];
            redirect   <= (r[5:2] == 4'd0);
            upd_valid  <= r[6];
            upd_pc     <= mix_pc[r[9:7]];
            upd_target <= mix_pc[r[12:10]];
            upd_type   <= br_type_e'(r[14:13]);
            upd_taken  <= r[15];
        end
        @(posedge clk);
        ready     <= 1'b0;
        redirect  <= 1'b0;
        upd_valid <= 1'b0;
        repeat (2) @(negedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/bpu_pkg.sv
rtl/bpu_btb.sv
rtl/bpu_bht.sv
rtl/bpu_pht.sv
rtl/bpu_ras.sv
rtl/bpu_pc_gen.sv
rtl/bpu.sv
test/tb_clk_gen.sv
test/tb_bpu.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bpu_pkg.sv
      - rtl/bpu_btb.sv
      - rtl/bpu_bht.sv
      - rtl/bpu_pht.sv
      - rtl/bpu_ras.sv
      - rtl/bpu_pc_gen.sv
      - rtl/bpu.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clk_gen.sv
      - test/tb_bpu.sv
